/* hdl/conv_arith_pkg.sv */
`default_nettype none

package conv_arith_pkg;

    // Datapath widths
    localparam int pix_w          = 18;
    localparam int coef_w         = 18;
    localparam int prod_w         = pix_w + coef_w;
    localparam int acc_w          = 48;
    localparam int res_w          = 16;
    localparam int shift_w        = 5;
    localparam int window_default = 3;

    // Signed result limits held at accumulator width
    localparam logic signed [acc_w-1:0] res_max = {{(acc_w-res_w+1){1'b0}}, {(res_w-1){1'b1}}};
    localparam logic signed [acc_w-1:0] res_min = ~res_max;

    // Sign extend a product onto the cascade
    function automatic logic signed [acc_w-1:0] ext_prod(input logic signed [prod_w-1:0] p);
        return {{(acc_w-prod_w){p[prod_w-1]}}, p};
    endfunction

    function automatic logic signed [res_w-1:0] sat_res(input logic signed [acc_w-1:0] v);
        if (v > res_max) begin
            return res_max[res_w-1:0];
        end
        if (v < res_min) begin
            return res_min[res_w-1:0];
        end
        return v[res_w-1:0];
    endfunction

endpackage

`default_nettype wire

/* hdl/conv_regs_pkg.sv */
`default_nettype none

package conv_regs_pkg;

    localparam int apb_addr_w = 12;

    // Word aligned register offsets
    typedef enum logic [apb_addr_w-1:0] {
        REG_CTRL     = 12'h000,
        REG_COEF     = 12'h004,
        REG_COEF_SEL = 12'h008,
        REG_STATUS   = 12'h00C
    } conv_reg_e;

    // REG_CTRL fields
    localparam int ctrl_enable_bit  = 0;
    localparam int ctrl_relu_bit    = 1;
    localparam int ctrl_restart_bit = 2;
    localparam int ctrl_shift_lsb   = 8;

    // REG_COEF_SEL fields
    localparam int coef_sel_ch_bit  = 4;
    localparam int coef_sel_row_lsb = 0;
    localparam int coef_sel_row_w   = 2;

endpackage

`default_nettype wire

/* hdl/conv_macc_stage.sv */
`default_nettype none

module conv_macc_stage #(
    parameter int DELAY = 1,
    parameter bit ACCUM = 1'b0
) (
    input  wire                                       clk,
    input  wire                                       rst,
    input  wire signed [conv_arith_pkg::pix_w-1:0]    i_a,
    input  wire signed [conv_arith_pkg::coef_w-1:0]   i_b,
    input  wire signed [conv_arith_pkg::acc_w-1:0]    i_pcin,
    input  wire                                       i_accum,
    output logic signed [conv_arith_pkg::acc_w-1:0]   o_pout
);

    logic signed [conv_arith_pkg::pix_w-1:0]  a_dly [DELAY];
    logic signed [conv_arith_pkg::coef_w-1:0] b_dly [DELAY];
    logic signed [conv_arith_pkg::prod_w-1:0] prod;
    logic signed [conv_arith_pkg::acc_w-1:0]  prod_ext;

    //////////////////////////////////////////////////////////////////////
    // Operand alignment and multiply
    //////////////////////////////////////////////////////////////////////

    // Deeper rows wait longer so the cascade lines up per column
    always_ff @(posedge clk) begin
        a_dly[0] <= i_a;
        b_dly[0] <= i_b;
        for (int i = 1; i < DELAY; i++) begin
            a_dly[i] <= a_dly[i-1];
            b_dly[i] <= b_dly[i-1];
        end
        prod <= a_dly[DELAY-1] * b_dly[DELAY-1];
    end

    assign prod_ext = conv_arith_pkg::ext_prod(prod);

    //////////////////////////////////////////////////////////////////////
    // Post adder
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            o_pout <= '0;
        end else if (ACCUM && i_accum) begin
            // Keep summing columns of the same window
            o_pout <= o_pout + i_pcin + prod_ext;
        end else begin
            o_pout <= i_pcin + prod_ext;
        end
    end

endmodule

`default_nettype wire

/* hdl/conv_array.sv */
`default_nettype none

module conv_array #(
    parameter int WINDOW = conv_arith_pkg::window_default
) (
    input  wire                                          clk,
    input  wire                                          rst,
    input  wire                                          i_enable,
    input  wire                                          i_restart,
    input  wire                                          i_col_valid,
    input  wire [WINDOW*conv_arith_pkg::pix_w-1:0]       i_col,
    input  wire [WINDOW-1:0]                             i_filter_init,
    input  wire signed [conv_arith_pkg::coef_w-1:0]      i_coef,
    output logic signed [conv_arith_pkg::acc_w-1:0]      o_psum,
    output logic                                         o_psum_valid
);

    localparam int cnt_w = $clog2(WINDOW);

    logic signed [conv_arith_pkg::coef_w-1:0] bank [WINDOW][WINDOW];
    logic signed [conv_arith_pkg::acc_w-1:0]  casc [WINDOW];
    logic [cnt_w-1:0]                         cnt;
    logic                                     col_accept;
    logic                                     first_col;
    logic                                     win_done;
    logic [WINDOW+1:0]                        done_dly;
    logic [WINDOW:0]                          accum_dly;

    assign col_accept = i_col_valid && i_enable;
    assign first_col  = col_accept && (cnt == cnt_w'(WINDOW - 1));
    assign win_done   = col_accept && (cnt == '0);

    //////////////////////////////////////////////////////////////////////
    // Filter bank, one shift register per row
    //////////////////////////////////////////////////////////////////////

    // First coefficient written ends up at the top entry
    always_ff @(posedge clk) begin
        for (int r = 0; r < WINDOW; r++) begin
            if (i_filter_init[r]) begin
                bank[r][0] <= i_coef;
                for (int i = 1; i < WINDOW; i++) begin
                    bank[r][i] <= bank[r][i-1];
                end
            end
        end
    end

    // Column counter that also indexes the bank
    always_ff @(posedge clk) begin
        if (rst || i_restart) begin
            cnt <= cnt_w'(WINDOW - 1);
        end else if (col_accept) begin
            if (cnt == '0) begin
                cnt <= cnt_w'(WINDOW - 1);
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Done flag lines up with the last slice output and the
    // accumulate flag with its post adder
    always_ff @(posedge clk) begin
        if (rst) begin
            done_dly  <= '0;
            accum_dly <= '0;
        end else begin
            done_dly  <= {done_dly[WINDOW:0], win_done};
            accum_dly <= {accum_dly[WINDOW-1:0], !first_col};
        end
    end

    assign o_psum_valid = done_dly[WINDOW+1];
    assign o_psum       = casc[WINDOW-1];

    //////////////////////////////////////////////////////////////////////
    // Slice cascade
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < WINDOW; k++) begin : g_row
        logic signed [conv_arith_pkg::pix_w-1:0]  pix;
        logic signed [conv_arith_pkg::coef_w-1:0] coef;
        logic signed [conv_arith_pkg::acc_w-1:0]  pcin;

        // Idle cycles feed zeros so the accumulator holds
        assign pix  = col_accept ? i_col[k*conv_arith_pkg::pix_w +: conv_arith_pkg::pix_w] : '0;
        assign coef = col_accept ? bank[k][cnt] : '0;

        if (k == 0) begin : g_head
            assign pcin = '0;
        end else begin : g_link
            assign pcin = casc[k-1];
        end

        conv_macc_stage #(
            .DELAY (k + 1),
            .ACCUM (k == WINDOW - 1)
        ) u_stage (
            .clk     (clk),
            .rst     (rst),
            .i_a     (pix),
            .i_b     (coef),
            .i_pcin  (pcin),
            .i_accum (accum_dly[WINDOW]),
            .o_pout  (casc[k])
        );
    end

    // Windows take WINDOW columns, so results never come back to back
    a_psum_spacing: assert property (@(posedge clk) disable iff (rst)
        o_psum_valid |=> !o_psum_valid);

endmodule

`default_nettype wire

/* hdl/conv_cfg_regs.sv */
`default_nettype none

module conv_cfg_regs #(
    parameter int WINDOW = conv_arith_pkg::window_default
) (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         i_psel,
    input  wire                                         i_penable,
    input  wire                                         i_pwrite,
    input  wire [conv_regs_pkg::apb_addr_w-1:0]         i_paddr,
    input  wire [31:0]                                  i_pwdata,
    input  wire                                         i_result_pulse,
    output logic [31:0]                                 o_prdata,
    output logic                                        o_pready,
    output logic                                        o_pslverr,
    output logic                                        o_enable,
    output logic                                        o_relu,
    output logic [conv_arith_pkg::shift_w-1:0]          o_shift,
    output logic                                        o_restart,
    output logic signed [conv_arith_pkg::coef_w-1:0]    o_coef,
    output logic [WINDOW-1:0]                           o_filter_init_ch0,
    output logic [WINDOW-1:0]                           o_filter_init_ch1
);

    conv_regs_pkg::conv_reg_e                    reg_addr;
    logic                                        access;
    logic                                        addr_ok;
    logic                                        wr;
    logic                                        sel_ch;
    logic [conv_regs_pkg::coef_sel_row_w-1:0]    sel_row;
    logic [31:0]                                 count;

    assign reg_addr = conv_regs_pkg::conv_reg_e'(i_paddr);
    assign access   = i_psel && i_penable;
    assign wr       = access && i_pwrite && addr_ok;
    assign o_pready  = 1'b1;
    assign o_pslverr = access && !addr_ok;

    // Address decode and read mux
    always_comb begin
        addr_ok  = 1'b1;
        o_prdata = '0;
        case (reg_addr)
            conv_regs_pkg::REG_CTRL: begin
                o_prdata[conv_regs_pkg::ctrl_enable_bit] = o_enable;
                o_prdata[conv_regs_pkg::ctrl_relu_bit]   = o_relu;
                o_prdata[conv_regs_pkg::ctrl_shift_lsb +: conv_arith_pkg::shift_w] = o_shift;
            end
            conv_regs_pkg::REG_COEF_SEL: begin
                o_prdata[conv_regs_pkg::coef_sel_ch_bit] = sel_ch;
                o_prdata[conv_regs_pkg::coef_sel_row_lsb +: conv_regs_pkg::coef_sel_row_w] = sel_row;
            end
            conv_regs_pkg::REG_STATUS: o_prdata = count;
            conv_regs_pkg::REG_COEF:   addr_ok = 1'b1;
            default:                   addr_ok = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Register writes, pulses and result count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            o_enable          <= 1'b0;
            o_relu            <= 1'b0;
            o_shift           <= '0;
            o_restart         <= 1'b0;
            sel_ch            <= 1'b0;
            sel_row           <= '0;
            o_filter_init_ch0 <= '0;
            o_filter_init_ch1 <= '0;
            count             <= '0;
        end else begin
            o_restart         <= wr && reg_addr == conv_regs_pkg::REG_CTRL
                                 && i_pwdata[conv_regs_pkg::ctrl_restart_bit];
            // One row of one channel per coefficient write
            for (int r = 0; r < WINDOW; r++) begin
                o_filter_init_ch0[r] <= wr && reg_addr == conv_regs_pkg::REG_COEF
                                        && !sel_ch && sel_row == r;
                o_filter_init_ch1[r] <= wr && reg_addr == conv_regs_pkg::REG_COEF
                                        && sel_ch && sel_row == r;
            end
            if (i_result_pulse) begin
                count <= count + 1'b1;
            end
            if (wr && reg_addr == conv_regs_pkg::REG_CTRL) begin
                o_enable <= i_pwdata[conv_regs_pkg::ctrl_enable_bit];
                o_relu   <= i_pwdata[conv_regs_pkg::ctrl_relu_bit];
                o_shift  <= i_pwdata[conv_regs_pkg::ctrl_shift_lsb +: conv_arith_pkg::shift_w];
            end
            if (wr && reg_addr == conv_regs_pkg::REG_COEF_SEL) begin
                sel_ch  <= i_pwdata[conv_regs_pkg::coef_sel_ch_bit];
                sel_row <= i_pwdata[conv_regs_pkg::coef_sel_row_lsb +: conv_regs_pkg::coef_sel_row_w];
            end
        end
    end

    // Coefficient bus lines up with the init pulse
    always_ff @(posedge clk) begin
        if (wr && reg_addr == conv_regs_pkg::REG_COEF) begin
            o_coef <= i_pwdata[conv_arith_pkg::coef_w-1:0];
        end
    end

    a_apb_setup: assert property (@(posedge clk) disable iff (rst)
        i_penable |-> i_psel && $past(i_psel));

    a_init_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({o_filter_init_ch1, o_filter_init_ch0}));

endmodule

`default_nettype wire

/* hdl/conv_channel_sum.sv */
`default_nettype none

module conv_channel_sum (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire signed [conv_arith_pkg::acc_w-1:0]      i_psum0,
    input  wire signed [conv_arith_pkg::acc_w-1:0]      i_psum1,
    input  wire                                         i_psum_valid0,
    input  wire                                         i_psum_valid1,
    input  wire                                         i_relu,
    input  wire [conv_arith_pkg::shift_w-1:0]           i_shift,
    output logic signed [conv_arith_pkg::res_w-1:0]     o_result,
    output logic                                        o_result_valid,
    output logic                                        o_result_pulse
);

    logic signed [conv_arith_pkg::acc_w-1:0] sum;
    logic signed [conv_arith_pkg::acc_w-1:0] shifted;
    logic signed [conv_arith_pkg::res_w-1:0] clipped;
    logic                                    psum_valid;

    assign psum_valid = i_psum_valid0 && i_psum_valid1;

    //////////////////////////////////////////////////////////////////////
    // Sum, scale, activation
    //////////////////////////////////////////////////////////////////////

    assign sum     = i_psum0 + i_psum1;
    assign shifted = sum >>> i_shift;

    always_comb begin
        if (i_relu && shifted[conv_arith_pkg::acc_w-1]) begin
            clipped = '0;
        end else begin
            clipped = conv_arith_pkg::sat_res(shifted);
        end
    end

    always_ff @(posedge clk) begin
        if (psum_valid) begin
            o_result <= clipped;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_result_valid <= 1'b0;
        end else begin
            o_result_valid <= psum_valid;
        end
    end

    // Feeds the status counter
    assign o_result_pulse = o_result_valid;

    // Both arrays see the same columns and counter history
    a_valid_match: assert property (@(posedge clk) disable iff (rst)
        i_psum_valid0 == i_psum_valid1);

endmodule

`default_nettype wire

/* hdl/conv_accel_top.sv */
`default_nettype none

module conv_accel_top #(
    parameter int WINDOW = conv_arith_pkg::window_default
) (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         i_psel,
    input  wire                                         i_penable,
    input  wire                                         i_pwrite,
    input  wire [conv_regs_pkg::apb_addr_w-1:0]         i_paddr,
    input  wire [31:0]                                  i_pwdata,
    input  wire                                         i_col_valid,
    input  wire [WINDOW*conv_arith_pkg::pix_w-1:0]      i_col_ch0,
    input  wire [WINDOW*conv_arith_pkg::pix_w-1:0]      i_col_ch1,
    output logic [31:0]                                 o_prdata,
    output logic                                        o_pready,
    output logic                                        o_pslverr,
    output logic signed [conv_arith_pkg::res_w-1:0]     o_result,
    output logic                                        o_result_valid
);

    logic                                     enable;
    logic                                     relu;
    logic [conv_arith_pkg::shift_w-1:0]       shift;
    logic                                     restart;
    logic signed [conv_arith_pkg::coef_w-1:0] coef;
    logic [WINDOW-1:0]                        init_ch0;
    logic [WINDOW-1:0]                        init_ch1;
    logic signed [conv_arith_pkg::acc_w-1:0]  psum0;
    logic signed [conv_arith_pkg::acc_w-1:0]  psum1;
    logic                                     psum_valid0;
    logic                                     psum_valid1;
    logic                                     result_pulse;

    conv_cfg_regs #(.WINDOW(WINDOW)) u_regs (
        .clk (clk), .rst (rst),
        .i_psel (i_psel), .i_penable (i_penable), .i_pwrite (i_pwrite),
        .i_paddr (i_paddr), .i_pwdata (i_pwdata), .i_result_pulse (result_pulse),
        .o_prdata (o_prdata), .o_pready (o_pready), .o_pslverr (o_pslverr),
        .o_enable (enable), .o_relu (relu), .o_shift (shift), .o_restart (restart),
        .o_coef (coef), .o_filter_init_ch0 (init_ch0), .o_filter_init_ch1 (init_ch1)
    );

    // One array per input channel
    conv_array #(.WINDOW(WINDOW)) u_array_ch0 (
        .clk (clk), .rst (rst), .i_enable (enable), .i_restart (restart),
        .i_col_valid (i_col_valid), .i_col (i_col_ch0), .i_filter_init (init_ch0),
        .i_coef (coef), .o_psum (psum0), .o_psum_valid (psum_valid0)
    );

    conv_array #(.WINDOW(WINDOW)) u_array_ch1 (
        .clk (clk), .rst (rst), .i_enable (enable), .i_restart (restart),
        .i_col_valid (i_col_valid), .i_col (i_col_ch1), .i_filter_init (init_ch1),
        .i_coef (coef), .o_psum (psum1), .o_psum_valid (psum_valid1)
    );

    conv_channel_sum u_sum (
        .clk (clk), .rst (rst),
        .i_psum0 (psum0), .i_psum1 (psum1),
        .i_psum_valid0 (psum_valid0), .i_psum_valid1 (psum_valid1),
        .i_relu (relu), .i_shift (shift),
        .o_result (o_result), .o_result_valid (o_result_valid),
        .o_result_pulse (result_pulse)
    );

endmodule

`default_nettype wire

/* tb/conv_accel_checker.sv */
`default_nettype none

module conv_accel_checker (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire signed [conv_arith_pkg::res_w-1:0]   i_result,
    input  wire                                      i_result_valid,
    input  wire [31:0]                               i_prdata,
    input  wire                                      i_pready,
    input  wire                                      i_pslverr,
    input  wire                                      i_rd_check,
    input  wire [31:0]                               i_rd_exp_data,
    input  wire                                      i_rd_exp_err,
    input  wire                                      i_exp_push,
    input  wire [31:0]                               i_exp_value,
    output int                                       o_pending,
    output int                                       o_errors
);

    localparam int res_w = conv_arith_pkg::res_w;

    int                      exp_q[$];
    logic signed [res_w-1:0] exp_res;

    initial begin
        o_pending = 0;
        o_errors  = 0;
    end

    //////////////////////////////////////////////////////////////////////
    // Result stream against the expected queue
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst) begin
            if (i_exp_push) begin
                exp_q.push_back($signed(i_exp_value));
            end
            if (i_result_valid) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: o_result_valid rose with no expected result queued (got %0d)",
                             $time, i_result);
                    o_errors++;
                end else begin
                    exp_res = res_w'(exp_q.pop_front());
                    if (i_result !== exp_res) begin
                        $display("CHECK FAILED at %0t: o_result expected %0d, got %0d",
                                 $time, exp_res, i_result);
                        o_errors++;
                    end
                end
            end
            // Read data is valid in the access phase once ready is high
            if (i_rd_check && i_pready) begin
                if (i_prdata !== i_rd_exp_data) begin
                    $display("CHECK FAILED at %0t: o_prdata expected %h, got %h",
                             $time, i_rd_exp_data, i_prdata);
                    o_errors++;
                end
                if (i_pslverr !== i_rd_exp_err) begin
                    $display("CHECK FAILED at %0t: o_pslverr expected %b, got %b",
                             $time, i_rd_exp_err, i_pslverr);
                    o_errors++;
                end
            end
            o_pending = exp_q.size();
        end
    end

endmodule

`default_nettype wire

/* tb/conv_accel_tb.sv */
`default_nettype none

module conv_accel_tb;

    localparam int window        = 3;
    localparam int pix_w         = conv_arith_pkg::pix_w;
    localparam int addr_w        = conv_regs_pkg::apb_addr_w;
    localparam int apb_timeout   = 16;
    localparam int drain_timeout = 200;

    logic                                    clk;
    logic                                    rst;
    logic                                    psel;
    logic                                    penable;
    logic                                    pwrite;
    logic [addr_w-1:0]                       paddr;
    logic [31:0]                             pwdata;
    logic                                    col_valid;
    logic [window*pix_w-1:0]                 col_ch0;
    logic [window*pix_w-1:0]                 col_ch1;
    logic [31:0]                             prdata;
    logic                                    pready;
    logic                                    pslverr;
    logic signed [conv_arith_pkg::res_w-1:0] result;
    logic                                    result_valid;

    // Expectations handed to the checker
    logic        rd_check;
    logic [31:0] rd_exp_data;
    logic        rd_exp_err;
    logic        exp_push;
    logic [31:0] exp_value;
    int          pending;
    int          check_errors;

    int          fd;
    int          tb_errors;
    int          test_count;
    bit          reading;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    conv_accel_top #(.WINDOW(window)) conv_accel_top_inst (
        .clk            (clk),
        .rst            (rst),
        .i_psel         (psel),
        .i_penable      (penable),
        .i_pwrite       (pwrite),
        .i_paddr        (paddr),
        .i_pwdata       (pwdata),
        .i_col_valid    (col_valid),
        .i_col_ch0      (col_ch0),
        .i_col_ch1      (col_ch1),
        .o_prdata       (prdata),
        .o_pready       (pready),
        .o_pslverr      (pslverr),
        .o_result       (result),
        .o_result_valid (result_valid)
    );

    conv_accel_checker result_checker (
        .clk            (clk),
        .rst            (rst),
        .i_result       (result),
        .i_result_valid (result_valid),
        .i_prdata       (prdata),
        .i_pready       (pready),
        .i_pslverr      (pslverr),
        .i_rd_check     (rd_check),
        .i_rd_exp_data  (rd_exp_data),
        .i_rd_exp_err   (rd_exp_err),
        .i_exp_push     (exp_push),
        .i_exp_value    (exp_value),
        .o_pending      (pending),
        .o_errors       (check_errors)
    );

    //////////////////////////////////////////////////////////////////////
    // Bus and stream drivers
    //////////////////////////////////////////////////////////////////////

    // Row 0 goes in the low bits
    function automatic logic [window*pix_w-1:0] pack_column(input int r0, input int r1,
                                                            input int r2);
        return {pix_w'(r2), pix_w'(r1), pix_w'(r0)};
    endfunction

    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] data, input logic [31:0] exp_data,
                                input logic exp_err);
        int n;
        @(posedge clk);
        col_valid <= 1'b0;
        psel      <= 1'b1;
        penable   <= 1'b0;
        pwrite    <= write;
        paddr     <= addr[addr_w-1:0];
        pwdata    <= data;
        @(posedge clk);
        penable     <= 1'b1;
        rd_check    <= !write;
        rd_exp_data <= exp_data;
        rd_exp_err  <= exp_err;
        n = 0;
        @(negedge clk);
        while (!pready && n < apb_timeout) begin
            @(negedge clk);
            n++;
        end
        if (!pready) begin
            $display("APB transfer to offset %h never saw pready", addr);
            tb_errors++;
        end
        // Access phase ends on this edge
        @(posedge clk);
        psel     <= 1'b0;
        penable  <= 1'b0;
        rd_check <= 1'b0;
    endtask

    task automatic drive_column(input logic valid, input logic [window*pix_w-1:0] c0,
                                input logic [window*pix_w-1:0] c1);
        @(posedge clk);
        col_valid <= valid;
        col_ch0   <= c0;
        col_ch1   <= c1;
    endtask

    task automatic queue_result(input int value);
        @(posedge clk);
        col_valid <= 1'b0;
        exp_push  <= 1'b1;
        exp_value <= value;
        @(posedge clk);
        exp_push  <= 1'b0;
    endtask

    // Drain outstanding results, then report the test
    task automatic finish_test(input string name, input int start_errors);
        int n;
        int errs;
        n = 0;
        @(negedge clk);
        while (pending != 0 && n < drain_timeout) begin
            @(negedge clk);
            n++;
        end
        if (pending != 0) begin
            $display("test %0s: timeout waiting for results", name);
            tb_errors++;
        end
        errs = tb_errors + check_errors - start_errors;
        if (errs == 0) begin
            $display("test %0s: passed", name);
        end else begin
            $display("test %0s: failed with %0d errors", name, errs);
        end
    endtask

    task automatic trace_error(input logic [7:0] tag);
        $display("malformed trace record with tag %c", tag);
        tb_errors++;
        reading = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Trace sequencer
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [7:0]  tag;
        string       name;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] err;
        int          v;
        int          a0;
        int          a1;
        int          a2;
        int          b0;
        int          b1;
        int          b2;
        int          code;
        int          ch;
        int          test_start;

        rst         <= 1'b1;
        psel        <= 1'b0;
        penable     <= 1'b0;
        pwrite      <= 1'b0;
        paddr       <= '0;
        pwdata      <= '0;
        col_valid   <= 1'b0;
        col_ch0     <= '0;
        col_ch1     <= '0;
        rd_check    <= 1'b0;
        rd_exp_data <= '0;
        rd_exp_err  <= 1'b0;
        exp_push    <= 1'b0;
        exp_value   <= '0;
        tb_errors  = 0;
        test_count = 0;
        test_start = 0;
        name       = "none";

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        fd = $fopen("tb/conv_accel_trace.txt", "r");
        reading = (fd != 0);
        if (fd == 0) begin
            $display("cannot open trace file tb/conv_accel_trace.txt");
            tb_errors++;
        end

        while (reading) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                reading = 1'b0;
            end else begin
                case (tag)
                    "#": begin
                        ch = 0;
                        while (ch != 10 && ch != -1) begin
                            ch = $fgetc(fd);
                        end
                    end
                    "T": begin
                        code = $fscanf(fd, " %s", name);
                        test_start = tb_errors + check_errors;
                        test_count++;
                    end
                    "W": begin
                        code = $fscanf(fd, " %h %h", addr, data);
                        if (code == 2) begin
                            apb_transfer(1'b1, addr, data, '0, 1'b0);
                        end else begin
                            trace_error(tag);
                        end
                    end
                    "R": begin
                        code = $fscanf(fd, " %h %h %h", addr, data, err);
                        if (code == 3) begin
                            apb_transfer(1'b0, addr, '0, data, err[0]);
                        end else begin
                            trace_error(tag);
                        end
                    end
                    "P": begin
                        code = $fscanf(fd, " %d %d %d %d %d %d %d", v, a0, a1, a2, b0, b1, b2);
                        if (code == 7) begin
                            drive_column(v != 0, pack_column(a0, a1, a2),
                                         pack_column(b0, b1, b2));
                        end else begin
                            trace_error(tag);
                        end
                    end
                    "X": begin
                        code = $fscanf(fd, " %d", v);
                        if (code == 1) begin
                            queue_result(v);
                        end else begin
                            trace_error(tag);
                        end
                    end
                    "E": finish_test(name, test_start);
                    default: trace_error(tag);
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        @(negedge clk);
        $display("tests: %0d, errors: %0d", test_count, tb_errors + check_errors);
        if (tb_errors + check_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/conv_accel_trace.txt */
# T name | W offset data | R offset data pslverr | X result | E    (offset, data hex)
# P valid ch0_r0 ch0_r1 ch0_r2 ch1_r0 ch1_r1 ch1_r2             (decimal)
T reset_values
P 1 1 2 3 4 5 6
P 1 7 8 9 1 2 3
P 1 1 1 1 1 1 1
P 0 0 0 0 0 0 0
R 000 00000000 0
R 00C 00000000 0
R 008 00000000 0
R 010 00000000 1
E
T single_window
W 008 00000000
W 004 00000001
W 004 00000002
W 004 00000003
W 008 00000001
W 004 00000004
W 004 00000005
W 004 00000006
W 008 00000002
W 004 00000007
W 004 00000008
W 004 00000009
W 008 00000010
W 004 FFFFFFFF
W 004 00000000
W 004 00000001
W 008 00000011
W 004 00000002
W 004 FFFFFFFE
W 004 00000003
W 008 00000012
W 004 00000001
W 004 00000001
W 004 FFFFFFFF
W 000 00000001
X 235
P 1 1 2 3 10 -3 2
P 1 4 5 6 0 5 -4
P 1 7 8 9 6 1 7
P 0 0 0 0 0 0 0
E
T back_to_back
X 49
X 96
X 11
P 1 1 1 1 1 1 1
P 1 1 1 1 1 1 1
P 1 1 1 1 1 1 1
P 1 1 1 1 0 0 0
P 1 2 2 2 0 0 0
P 1 3 3 3 0 0 0
P 1 0 0 0 1 2 3
P 1 0 0 0 -1 -2 -3
P 1 0 0 0 2 0 -2
P 0 0 0 0 0 0 0
E
T saturation
W 000 00000201
X 32767
X -32768
X -11
P 1 100000 100000 100000 0 0 0
P 1 100000 100000 100000 0 0 0
P 1 100000 100000 100000 0 0 0
P 1 -100000 -100000 -100000 0 0 0
P 1 -100000 -100000 -100000 0 0 0
P 1 -100000 -100000 -100000 0 0 0
P 1 -1 -1 -1 1 1 1
P 1 -1 -1 -1 1 1 1
P 1 -1 -1 -1 1 1 1
P 0 0 0 0 0 0 0
E
T relu
W 000 00000203
X 0
X 45
P 1 -100000 -100000 -100000 0 0 0
P 1 -100000 -100000 -100000 0 0 0
P 1 -100000 -100000 -100000 0 0 0
P 1 4 4 4 0 0 0
P 1 4 4 4 0 0 0
P 1 4 4 4 0 0 0
P 0 0 0 0 0 0 0
E
T restart
W 000 00000001
P 1 50 50 50 50 50 50
P 0 0 0 0 0 0 0
W 000 00000005
X 17
P 1 1 0 0 0 0 1
P 1 0 1 0 0 0 0
P 1 0 0 1 1 0 0
P 0 0 0 0 0 0 0
E
T result_count
R 00C 0000000A 0
R 000 00000001 0
R 008 00000012 0
E

/* sim.f */
hdl/conv_arith_pkg.sv
hdl/conv_regs_pkg.sv
hdl/conv_macc_stage.sv
hdl/conv_array.sv
hdl/conv_cfg_regs.sv
hdl/conv_channel_sum.sv
hdl/conv_accel_top.sv
tb/conv_accel_checker.sv
tb/conv_accel_tb.sv

/* Bender.yml */
package:
  name: conv_accel

sources:
  - hdl/conv_arith_pkg.sv
  - hdl/conv_regs_pkg.sv
  - hdl/conv_macc_stage.sv
  - hdl/conv_array.sv
  - hdl/conv_cfg_regs.sv
  - hdl/conv_channel_sum.sv
  - hdl/conv_accel_top.sv
  - target: test
    files:
      - tb/conv_accel_checker.sv
      - tb/conv_accel_tb.sv
